// File: hdl/csr_cfg.svh
// Widths, CSR addresses and reset values for the machine-mode CSR file.
// Only machine mode exists, so mpp is a constant and not a register.
// The counter count must stay at or below 31, because index 31 is the
// all-counters alias.
`ifndef CSR_CFG_SVH
`define CSR_CFG_SVH

// datapath widths
`define CSR_XLEN            32
`define CSR_ADDR_W          12
`define CSR_CAUSE_W         6
`define CSR_TVEC_W          24

// machine trap registers
`define CSR_ADDR_MSTATUS    12'h300
`define CSR_ADDR_MTVEC      12'h305
`define CSR_ADDR_MEPC       12'h341
`define CSR_ADDR_MCAUSE     12'h342
`define CSR_ADDR_MHARTID    12'hF14

// performance counter block
`define CSR_ADDR_PCCR_BASE  12'h780
`define CSR_ADDR_PCCR_ALL   12'h79F
`define CSR_ADDR_PCER       12'h7A0
`define CSR_ADDR_PCMR       12'h7A1
`define N_PERF_COUNTERS     11

// reset and constant values
`define PCMR_RESET          2'b11
`define CSR_MPP_MACHINE     2'b11

`endif

// File: hdl/csr_pkg.sv
// Shared types for the machine-mode CSR file.
// The struct layouts follow the architectural bit positions, so a struct
// view and the raw word always line up bit for bit.
`include "csr_cfg.svh"

package csr_pkg;

  // csr access operation, same encoding as the core decoder
  typedef enum logic [1:0] {
    CSR_OP_NONE  = 2'b00,
    CSR_OP_WRITE = 2'b01,
    CSR_OP_SET   = 2'b10,
    CSR_OP_CLEAR = 2'b11
  } csr_op_e;

  // mstatus, only mie, mpie and mpp are live
  typedef struct packed {
    logic [18:0] rsvd_31_13;
    logic [1:0]  mpp;
    logic [2:0]  rsvd_10_8;
    logic        mpie;
    logic [2:0]  rsvd_6_4;
    logic        mie;
    logic [2:0]  rsvd_2_0;
  } mstatus_t;

  // mcause, interrupt flag on top, code in the low bits
  typedef struct packed {
    logic        irq;
    logic [25:0] rsvd_30_5;
    logic [4:0]  code;
  } mcause_t;

  // one write word, seen raw or through the register it targets
  typedef union packed {
    logic [`CSR_XLEN-1:0] raw;
    mstatus_t             mstatus;
    mcause_t              mcause;
  } csr_word_u;

  // core events feeding the performance counters
  typedef struct packed {
    logic id_valid;
    logic is_decoding;
    logic is_compressed;
    logic imiss;
    logic pc_set;
    logic jump;
    logic branch;
    logic branch_taken;
    logic ld_stall;
    logic jr_stall;
    logic mem_load;
    logic mem_store;
  } perf_events_t;

endpackage

// File: hdl/csr_op_alu.sv
// Read-modify-write stage shared by every CSR block.
// csr_rdata_i must be the same-cycle read of the addressed register.
// Purely combinational, and the write strobe is valid for this cycle only.
`timescale 1ns/1ps
`include "csr_cfg.svh"

module csr_op_alu (
  input  logic                 csr_access_i,
  input  csr_pkg::csr_op_e     csr_op_i,
  input  logic [`CSR_XLEN-1:0] csr_wdata_i,
  input  logic [`CSR_XLEN-1:0] csr_rdata_i,
  output csr_pkg::csr_word_u   csr_wdata_o,
  output logic                 csr_we_o
);

  import csr_pkg::*;

  logic [`CSR_XLEN-1:0] new_word;

  // new register value from old value and operand
  always_comb begin
    case (csr_op_i)
      CSR_OP_SET:   new_word = csr_rdata_i | csr_wdata_i;
      // clear keeps old bits where data is zero
      CSR_OP_CLEAR: new_word = csr_rdata_i & ~csr_wdata_i;
      // write, and none which is never strobed anyway
      default:      new_word = csr_wdata_i;
    endcase
  end

  assign csr_wdata_o = new_word;

  // only a real access with a real op writes
  assign csr_we_o = csr_access_i & (csr_op_i != CSR_OP_NONE);

  // an unknown op would make every block's write enable unknown
  always_comb begin
    if (csr_access_i) begin
      assert final (!$isunknown(csr_op_i))
        else $error("csr op is unknown during an active access");
    end
  end

endmodule

// File: hdl/csr_trap_regs.sv
// Machine trap registers: mstatus, mtvec, mepc, mcause and mhartid.
// mtvec is not writable, it always reflects the boot address.
// A trap save wins over a CSR write in the same cycle, and the controller
// must never raise save and mret together.
`timescale 1ns/1ps
`include "csr_cfg.svh"

module csr_trap_regs (
  input  logic                    clk,
  input  logic                    rst_n,
  // shared write path
  input  logic [`CSR_ADDR_W-1:0]  csr_addr_i,
  input  csr_pkg::csr_word_u      csr_wdata_i,
  input  logic                    csr_we_i,
  // static ids and boot vector
  input  logic [3:0]              core_id_i,
  input  logic [5:0]              cluster_id_i,
  input  logic [`CSR_TVEC_W-1:0]  boot_addr_i,
  // trap controls
  input  logic [`CSR_XLEN-1:0]    pc_if_i,
  input  logic [`CSR_XLEN-1:0]    pc_id_i,
  input  logic                    exc_save_if_i,
  input  logic                    exc_save_id_i,
  input  logic                    csr_save_cause_i,
  input  logic                    csr_restore_mret_i,
  input  logic [`CSR_CAUSE_W-1:0] exc_cause_i,
  // outputs
  output logic [`CSR_XLEN-1:0]    rdata_o,
  output logic [`CSR_XLEN-1:0]    epc_o,
  output logic [`CSR_TVEC_W-1:0]  mtvec_o,
  output logic                    m_irq_enable_o
);

  import csr_pkg::*;

  // state
  logic                    mie_q, mie_n;
  logic                    mpie_q, mpie_n;
  logic [`CSR_XLEN-1:0]    mepc_q, mepc_n;
  logic [`CSR_CAUSE_W-1:0] mcause_q, mcause_n;

  // read views in architectural layout
  mstatus_t                status_view;
  mcause_t                 cause_view;
  logic [`CSR_XLEN-1:0]    exception_pc;

  //////////////////////////////////////////////////
  // read decode
  //////////////////////////////////////////////////

  always_comb begin
    status_view      = '0;
    status_view.mpp  = `CSR_MPP_MACHINE;
    status_view.mpie = mpie_q;
    status_view.mie  = mie_q;
    // cause stored compact, widened on read
    cause_view       = '0;
    cause_view.irq   = mcause_q[`CSR_CAUSE_W-1];
    cause_view.code  = mcause_q[`CSR_CAUSE_W-2:0];
  end

  // zero outside own address range, so the top can OR
  always_comb begin
    case (csr_addr_i)
      `CSR_ADDR_MSTATUS: rdata_o = status_view;
      `CSR_ADDR_MTVEC:   rdata_o = {boot_addr_i, 8'h00};
      `CSR_ADDR_MEPC:    rdata_o = mepc_q;
      `CSR_ADDR_MCAUSE:  rdata_o = cause_view;
      // cluster in 10:5, core in 3:0
      `CSR_ADDR_MHARTID: rdata_o = {21'b0, cluster_id_i, 1'b0, core_id_i};
      default:           rdata_o = '0;
    endcase
  end

  //////////////////////////////////////////////////
  // write decode, save and mret
  //////////////////////////////////////////////////

  // pc of the trapping stage
  assign exception_pc = exc_save_if_i ? pc_if_i : pc_id_i;

  always_comb begin
    mie_n    = mie_q;
    mpie_n   = mpie_q;
    mepc_n   = mepc_q;
    mcause_n = mcause_q;

    // plain csr writes first
    if (csr_we_i) begin
      case (csr_addr_i)
        `CSR_ADDR_MSTATUS: begin
          mie_n  = csr_wdata_i.mstatus.mie;
          mpie_n = csr_wdata_i.mstatus.mpie;
        end
        `CSR_ADDR_MEPC: begin
          mepc_n = csr_wdata_i.raw;
        end
        `CSR_ADDR_MCAUSE: begin
          mcause_n = {csr_wdata_i.mcause.irq, csr_wdata_i.mcause.code};
        end
        default: begin
        end
      endcase
    end

    // trap entry overrides any write above
    if (csr_save_cause_i) begin
      mepc_n   = exception_pc;
      mcause_n = exc_cause_i;
      mpie_n   = mie_q;
      mie_n    = 1'b0;
    end else if (csr_restore_mret_i) begin
      // back from trap, re-arm mpie
      mie_n  = mpie_q;
      mpie_n = 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mie_q    <= 1'b0;
      mpie_q   <= 1'b0;
      mepc_q   <= '0;
      mcause_q <= '0;
    end else begin
      mie_q    <= mie_n;
      mpie_q   <= mpie_n;
      mepc_q   <= mepc_n;
      mcause_q <= mcause_n;
    end
  end

  // direct outputs
  assign epc_o          = mepc_q;
  assign mtvec_o        = boot_addr_i;
  assign m_irq_enable_o = mie_q;

  // controller handshake rules
  assert property (@(posedge clk) disable iff (!rst_n)
    !(csr_save_cause_i && csr_restore_mret_i))
    else $error("trap save and mret raised together");

  assert property (@(posedge clk) disable iff (!rst_n)
    !(exc_save_if_i && exc_save_id_i))
    else $error("both pc select strobes raised together");

endmodule

// File: hdl/perf_counters.sv
// Event-driven performance counters with enable (PCER) and mode (PCMR).
// An event reaches its counter two edges later, first into a registered
// increment flag, then into the count. A CSR write beats an increment.
// Address 79F writes every counter and reads back as zero.
`timescale 1ns/1ps
`include "csr_cfg.svh"

module perf_counters (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic [`CSR_ADDR_W-1:0] csr_addr_i,
  input  csr_pkg::csr_word_u     csr_wdata_i,
  input  logic                   csr_we_i,
  input  csr_pkg::perf_events_t  events_i,
  output logic [`CSR_XLEN-1:0]   rdata_o
);

  import csr_pkg::*;

  localparam int NCNT = `N_PERF_COUNTERS;
  localparam logic [`CSR_ADDR_W-1:0] PCCR_BASE = `CSR_ADDR_PCCR_BASE;

  // event qualification
  logic                            id_valid_q;
  logic [NCNT-1:0]                 pccr_in;
  logic [NCNT-1:0]                 pccr_inc;
  logic [NCNT-1:0]                 pccr_inc_q;

  // counter, enable and mode state
  logic [NCNT-1:0][`CSR_XLEN-1:0]  pccr_q, pccr_n;
  logic [NCNT-1:0]                 pcer_q;
  logic [1:0]                      pcmr_q;

  // address decode
  logic                            is_pccr;
  logic                            is_pcer;
  logic                            is_pcmr;
  logic                            pccr_all_sel;
  logic [4:0]                      pccr_index;

  //////////////////////////////////////////////////
  // event sources
  //////////////////////////////////////////////////

  // cycles
  assign pccr_in[0]  = 1'b1;
  // decoded instructions
  assign pccr_in[1]  = events_i.id_valid & events_i.is_decoding;
  // hazards, qualified by last cycle's valid
  assign pccr_in[2]  = events_i.ld_stall & id_valid_q;
  assign pccr_in[3]  = events_i.jr_stall & id_valid_q;
  // fetch wait, not counting redirects
  assign pccr_in[4]  = events_i.imiss & ~events_i.pc_set;
  // memory traffic
  assign pccr_in[5]  = events_i.mem_load;
  assign pccr_in[6]  = events_i.mem_store;
  // control flow
  assign pccr_in[7]  = events_i.jump & id_valid_q;
  assign pccr_in[8]  = events_i.branch & id_valid_q;
  assign pccr_in[9]  = events_i.branch & events_i.branch_taken & id_valid_q;
  // compressed decoded instructions
  assign pccr_in[10] = events_i.id_valid & events_i.is_decoding &
                       events_i.is_compressed;

  // per-event enable and global enable
  assign pccr_inc = pccr_in & pcer_q & {NCNT{pcmr_q[0]}};

  //////////////////////////////////////////////////
  // address decode and read
  //////////////////////////////////////////////////

  // 780..79F window, low five bits pick the counter
  assign is_pccr      = (csr_addr_i[11:5] == PCCR_BASE[11:5]);
  assign pccr_index   = csr_addr_i[4:0];
  assign pccr_all_sel = (csr_addr_i == `CSR_ADDR_PCCR_ALL);
  assign is_pcer      = (csr_addr_i == `CSR_ADDR_PCER);
  assign is_pcmr      = (csr_addr_i == `CSR_ADDR_PCMR);

  always_comb begin
    rdata_o = '0;
    if (is_pcer) begin
      rdata_o[NCNT-1:0] = pcer_q;
    end
    if (is_pcmr) begin
      rdata_o[1:0] = pcmr_q;
    end
    // unpopulated indices, 31 included, fall through as zero
    if (is_pccr) begin
      for (int i = 0; i < NCNT; i++) begin
        if (pccr_index == i) begin
          rdata_o = pccr_q[i];
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // counter update
  //////////////////////////////////////////////////

  always_comb begin
    for (int i = 0; i < NCNT; i++) begin
      pccr_n[i] = pccr_q[i];
      // step unless saturating at all ones
      if (pccr_inc_q[i] && ((pccr_q[i] != '1) || !pcmr_q[1])) begin
        pccr_n[i] = pccr_q[i] + 1'b1;
      end
      // csr write takes the slot
      if (csr_we_i && is_pccr && (pccr_all_sel || (pccr_index == i))) begin
        pccr_n[i] = csr_wdata_i.raw;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      id_valid_q <= 1'b0;
      pccr_inc_q <= '0;
      pccr_q     <= '0;
      pcer_q     <= '0;
      pcmr_q     <= `PCMR_RESET;
    end else begin
      id_valid_q <= events_i.id_valid;
      pccr_inc_q <= pccr_inc;
      pccr_q     <= pccr_n;
      if (csr_we_i && is_pcer) begin
        pcer_q <= csr_wdata_i.raw[NCNT-1:0];
      end
      if (csr_we_i && is_pcmr) begin
        pcmr_q <= csr_wdata_i.raw[1:0];
      end
    end
  end

  // software only targets populated counters or the all alias
  assert property (@(posedge clk) disable iff (!rst_n)
    (csr_we_i && is_pccr) |-> (pccr_all_sel || (pccr_index < NCNT)))
    else $error("write to unpopulated performance counter %0d", pccr_index);

endmodule

// File: hdl/csr_file.sv
// Machine-mode CSR file top level.
// Reads are combinational from the address, writes land on the next edge.
// No handshake, every input is a plain level or single-cycle strobe.
`timescale 1ns/1ps
`include "csr_cfg.svh"

module csr_file (
  input  logic                    clk,
  input  logic                    rst_n,
  // csr access port
  input  logic                    csr_access_i,
  input  logic [`CSR_ADDR_W-1:0]  csr_addr_i,
  input  csr_pkg::csr_op_e        csr_op_i,
  input  logic [`CSR_XLEN-1:0]    csr_wdata_i,
  output logic [`CSR_XLEN-1:0]    csr_rdata_o,
  // ids and boot vector
  input  logic [3:0]              core_id_i,
  input  logic [5:0]              cluster_id_i,
  input  logic [`CSR_TVEC_W-1:0]  boot_addr_i,
  // trap interface
  input  logic [`CSR_XLEN-1:0]    pc_if_i,
  input  logic [`CSR_XLEN-1:0]    pc_id_i,
  input  logic                    exc_save_if_i,
  input  logic                    exc_save_id_i,
  input  logic                    csr_save_cause_i,
  input  logic                    csr_restore_mret_i,
  input  logic [`CSR_CAUSE_W-1:0] exc_cause_i,
  output logic [`CSR_XLEN-1:0]    epc_o,
  output logic [`CSR_TVEC_W-1:0]  mtvec_o,
  output logic                    m_irq_enable_o,
  // performance events
  input  csr_pkg::perf_events_t   perf_events_i
);

  import csr_pkg::*;

  csr_word_u            csr_wdata;
  logic                 csr_we;
  logic [`CSR_XLEN-1:0] trap_rdata;
  logic [`CSR_XLEN-1:0] perf_rdata;

  // each block zeroes its read word off its own addresses
  assign csr_rdata_o = trap_rdata | perf_rdata;

  // shared read-modify-write
  csr_op_alu csr_op_alu_inst (
    .csr_access_i (csr_access_i),
    .csr_op_i     (csr_op_i),
    .csr_wdata_i  (csr_wdata_i),
    .csr_rdata_i  (csr_rdata_o),
    .csr_wdata_o  (csr_wdata),
    .csr_we_o     (csr_we)
  );

  // mstatus, mtvec, mepc, mcause, mhartid
  csr_trap_regs csr_trap_regs_inst (
    .clk                (clk),
    .rst_n              (rst_n),
    .csr_addr_i         (csr_addr_i),
    .csr_wdata_i        (csr_wdata),
    .csr_we_i           (csr_we),
    .core_id_i          (core_id_i),
    .cluster_id_i       (cluster_id_i),
    .boot_addr_i        (boot_addr_i),
    .pc_if_i            (pc_if_i),
    .pc_id_i            (pc_id_i),
    .exc_save_if_i      (exc_save_if_i),
    .exc_save_id_i      (exc_save_id_i),
    .csr_save_cause_i   (csr_save_cause_i),
    .csr_restore_mret_i (csr_restore_mret_i),
    .exc_cause_i        (exc_cause_i),
    .rdata_o            (trap_rdata),
    .epc_o              (epc_o),
    .mtvec_o            (mtvec_o),
    .m_irq_enable_o     (m_irq_enable_o)
  );

  // counters, PCER, PCMR
  perf_counters perf_counters_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .csr_addr_i  (csr_addr_i),
    .csr_wdata_i (csr_wdata),
    .csr_we_i    (csr_we),
    .events_i    (perf_events_i),
    .rdata_o     (perf_rdata)
  );

endmodule

// File: test/csr_file_tb.sv
// Directed testbench for the machine-mode CSR file and its counters.
// Inputs change on the rising edge and outputs are sampled on the falling edge.
// Random pcs and write data come from $random with a fixed seed.
// The first failing check ends the run.
`timescale 1ns/1ps
`include "csr_cfg.svh"

module csr_file_tb;

  import csr_pkg::*;

  // the directed tests need under 200 cycles
  localparam int MAX_CYCLES = 2000;
  localparam logic [`CSR_TVEC_W-1:0] BOOT_ADDR = 24'h1C_0080;
  localparam logic [3:0] CORE_ID = 4'h5;
  localparam logic [5:0] CLUSTER_ID = 6'h2A;

  logic                    clk;
  logic                    rst_n;
  logic                    csr_access;
  logic [`CSR_ADDR_W-1:0]  csr_addr;
  csr_op_e                 csr_op;
  logic [`CSR_XLEN-1:0]    csr_wdata;
  logic [`CSR_XLEN-1:0]    csr_rdata;
  logic [`CSR_XLEN-1:0]    pc_if;
  logic [`CSR_XLEN-1:0]    pc_id;
  logic                    exc_save_if;
  logic                    exc_save_id;
  logic                    save_cause;
  logic                    restore_mret;
  logic [`CSR_CAUSE_W-1:0] exc_cause;
  logic [`CSR_XLEN-1:0]    epc;
  logic [`CSR_TVEC_W-1:0]  mtvec;
  logic                    m_irq_enable;
  perf_events_t            perf_events;
  integer                  seed;
  int                      cycle_count = 0;

  csr_file csr_file_inst (
    .clk (clk), .rst_n (rst_n),
    .csr_access_i (csr_access), .csr_addr_i (csr_addr), .csr_op_i (csr_op),
    .csr_wdata_i (csr_wdata), .csr_rdata_o (csr_rdata),
    .core_id_i (CORE_ID), .cluster_id_i (CLUSTER_ID), .boot_addr_i (BOOT_ADDR),
    .pc_if_i (pc_if), .pc_id_i (pc_id),
    .exc_save_if_i (exc_save_if), .exc_save_id_i (exc_save_id),
    .csr_save_cause_i (save_cause), .csr_restore_mret_i (restore_mret),
    .exc_cause_i (exc_cause), .epc_o (epc), .mtvec_o (mtvec),
    .m_irq_enable_o (m_irq_enable), .perf_events_i (perf_events)
  );

  always #10 clk = ~clk;

  // run limit
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= MAX_CYCLES) begin
      $display("timeout: no result after %0d cycles", MAX_CYCLES);
      $display("Simulation finished: FAIL");
      $fatal(1, "run stopped by cycle limit");
    end
  end

  //////////////////////////////////////////////////
  // compare tasks and reference values
  //////////////////////////////////////////////////

  task automatic check_word(input string test_name, input csr_word_u exp, input csr_word_u act);
    if (exp.raw !== act.raw) begin
      $display("Error: %s expected %08h actual %08h", test_name, exp.raw, act.raw);
      $display("Simulation finished: FAIL");
      $fatal(1, "word mismatch");
    end
  endtask

  task automatic check_bit(input string test_name, input logic exp, input logic act);
    if (exp !== act) begin
      $display("Error: %s expected %b actual %b", test_name, exp, act);
      $display("Simulation finished: FAIL");
      $fatal(1, "bit mismatch");
    end
  endtask

  // mpp fixed at machine mode, mpie bit 7, mie bit 3
  function automatic logic [31:0] mstatus_word(input logic mie, input logic mpie);
    return 32'h0000_1800 | ({31'b0, mpie} << 7) | ({31'b0, mie} << 3);
  endfunction

  // irq flag on top, 5-bit code at the bottom
  function automatic logic [31:0] cause_word(input logic [5:0] cause);
    return {cause[5], 26'b0, cause[4:0]};
  endfunction

  // counter after a number of increments
  function automatic logic [31:0] count_model(input logic [31:0] start, input int steps,
                                              input logic sat);
    logic [31:0] cnt;
    cnt = start;
    for (int i = 0; i < steps; i++) begin
      if (!(sat && cnt == 32'hFFFF_FFFF)) cnt = cnt + 1;
    end
    return cnt;
  endfunction

  //////////////////////////////////////////////////
  // bus drivers
  //////////////////////////////////////////////////

  // one access cycle that returns on the edge where the write lands
  task automatic write_csr(input logic access, input logic [11:0] addr, input csr_op_e op,
                           input logic [31:0] data);
    @(posedge clk);
    csr_access <= access;
    csr_addr   <= addr;
    csr_op     <= op;
    csr_wdata  <= data;
    @(posedge clk);
    csr_access <= 1'b0;
    csr_op     <= CSR_OP_NONE;
  endtask

  // read the current address right after a write
  task automatic check_now(input string test_name, input logic [31:0] exp);
    @(negedge clk);
    check_word(test_name, exp, csr_rdata);
  endtask

  task automatic expect_csr(input string test_name, input logic [11:0] addr,
                            input logic [31:0] exp);
    @(posedge clk);
    csr_addr <= addr;
    @(negedge clk);
    check_word(test_name, exp, csr_rdata);
  endtask

  // save pulse with an optional mepc write in the same cycle
  task automatic trap_save(input logic sel_if, input logic [31:0] if_pc, input logic [31:0] id_pc,
                           input logic [5:0] cause, input logic with_write,
                           input logic [31:0] data);
    @(posedge clk);
    pc_if       <= if_pc;
    pc_id       <= id_pc;
    exc_save_if <= sel_if;
    exc_save_id <= !sel_if;
    save_cause  <= 1'b1;
    exc_cause   <= cause;
    csr_access  <= with_write;
    csr_addr    <= `CSR_ADDR_MEPC;
    csr_op      <= CSR_OP_WRITE;
    csr_wdata   <= data;
    @(posedge clk);
    exc_save_if <= 1'b0;
    exc_save_id <= 1'b0;
    save_cause  <= 1'b0;
    csr_access  <= 1'b0;
    csr_op      <= CSR_OP_NONE;
  endtask

  task automatic mret_pulse();
    @(posedge clk);
    restore_mret <= 1'b1;
    @(posedge clk);
    restore_mret <= 1'b0;
  endtask

  // load pulses with optional stores and 3 idle cycles after
  task automatic pulse_loads(input int count, input logic with_store);
    repeat (count) begin
      @(posedge clk);
      perf_events.mem_load  <= 1'b1;
      perf_events.mem_store <= with_store;
      @(posedge clk);
      perf_events.mem_load  <= 1'b0;
      perf_events.mem_store <= 1'b0;
    end
    repeat (3) @(posedge clk);
  endtask

  //////////////////////////////////////////////////
  // directed tests
  //////////////////////////////////////////////////

  task automatic test_reset_values();
    string name;
    name = "test_reset_values";
    expect_csr(name, `CSR_ADDR_MSTATUS, 32'h0000_1800);
    check_bit(name, 1'b0, m_irq_enable);
    expect_csr(name, `CSR_ADDR_MEPC, 32'h0);
    expect_csr(name, `CSR_ADDR_MCAUSE, 32'h0);
    expect_csr(name, `CSR_ADDR_PCER, 32'h0);
    expect_csr(name, `CSR_ADDR_PCMR, 32'h3);
    expect_csr(name, `CSR_ADDR_MTVEC, {BOOT_ADDR, 8'h00});
    check_word(name, {8'h00, BOOT_ADDR}, {8'h00, mtvec});
    // cluster at 10:5, core at 3:0
    expect_csr(name, `CSR_ADDR_MHARTID, ({26'b0, CLUSTER_ID} << 5) | {28'b0, CORE_ID});
  endtask

  task automatic test_csr_ops();
    string       name;
    logic [31:0] model;
    logic [31:0] operand;
    name  = "test_csr_ops";
    model = 32'h0;
    operand = $random(seed);
    write_csr(1'b1, `CSR_ADDR_MEPC, CSR_OP_WRITE, operand);
    model = operand;
    check_now(name, model);
    operand = $random(seed);
    write_csr(1'b1, `CSR_ADDR_MEPC, CSR_OP_SET, operand);
    model = model | operand;
    check_now(name, model);
    operand = $random(seed);
    write_csr(1'b1, `CSR_ADDR_MEPC, CSR_OP_CLEAR, operand);
    model = model & ~operand;
    check_now(name, model);
    // none op and idle access leave mepc alone
    write_csr(1'b1, `CSR_ADDR_MEPC, CSR_OP_NONE, $random(seed));
    check_now(name, model);
    write_csr(1'b0, `CSR_ADDR_MEPC, CSR_OP_WRITE, $random(seed));
    check_now(name, model);
    // mstatus keeps only mie and mpie
    write_csr(1'b1, `CSR_ADDR_MSTATUS, CSR_OP_WRITE, 32'hFFFF_FFFF);
    check_now(name, mstatus_word(1'b1, 1'b1));
    check_bit(name, 1'b1, m_irq_enable);
    write_csr(1'b1, `CSR_ADDR_MSTATUS, CSR_OP_CLEAR, 32'h0000_0008);
    check_now(name, mstatus_word(1'b0, 1'b1));
    check_bit(name, 1'b0, m_irq_enable);
    write_csr(1'b1, `CSR_ADDR_MSTATUS, CSR_OP_SET, 32'h0000_0008);
    check_now(name, mstatus_word(1'b1, 1'b1));
    check_bit(name, 1'b1, m_irq_enable);
    write_csr(1'b1, `CSR_ADDR_MSTATUS, CSR_OP_WRITE, 32'h0);
    check_now(name, mstatus_word(1'b0, 1'b0));
    check_bit(name, 1'b0, m_irq_enable);
  endtask

  task automatic test_trap_save_mret();
    string       name;
    logic [31:0] pc_a;
    logic [31:0] pc_b;
    logic [31:0] operand;
    name = "test_trap_save_mret";
    write_csr(1'b1, `CSR_ADDR_MSTATUS, CSR_OP_WRITE, 32'h0000_0008);
    // save from the IF stage
    pc_a = $random(seed);
    pc_b = $random(seed);
    trap_save(1'b1, pc_a, pc_b, 6'h2B, 1'b0, 32'h0);
    @(negedge clk);
    check_word(name, pc_a, epc);
    expect_csr(name, `CSR_ADDR_MEPC, pc_a);
    expect_csr(name, `CSR_ADDR_MCAUSE, cause_word(6'h2B));
    expect_csr(name, `CSR_ADDR_MSTATUS, mstatus_word(1'b0, 1'b1));
    check_bit(name, 1'b0, m_irq_enable);
    mret_pulse();
    expect_csr(name, `CSR_ADDR_MSTATUS, mstatus_word(1'b1, 1'b1));
    check_bit(name, 1'b1, m_irq_enable);
    // save from the ID stage
    pc_a = $random(seed);
    pc_b = $random(seed);
    trap_save(1'b0, pc_a, pc_b, 6'h02, 1'b0, 32'h0);
    @(negedge clk);
    check_word(name, pc_b, epc);
    expect_csr(name, `CSR_ADDR_MEPC, pc_b);
    expect_csr(name, `CSR_ADDR_MCAUSE, cause_word(6'h02));
    expect_csr(name, `CSR_ADDR_MSTATUS, mstatus_word(1'b0, 1'b1));
    mret_pulse();
    expect_csr(name, `CSR_ADDR_MSTATUS, mstatus_word(1'b1, 1'b1));
    // save wins over a mepc write
    pc_a = $random(seed);
    pc_b = $random(seed);
    operand = $random(seed);
    trap_save(1'b1, pc_a, pc_b, 6'h05, 1'b1, operand);
    expect_csr(name, `CSR_ADDR_MEPC, pc_a);
    check_word(name, pc_a, epc);
    expect_csr(name, `CSR_ADDR_MSTATUS, mstatus_word(1'b0, 1'b1));
    // mret from a cleared mpie still re-arms mpie
    write_csr(1'b1, `CSR_ADDR_MSTATUS, CSR_OP_WRITE, 32'h0);
    mret_pulse();
    expect_csr(name, `CSR_ADDR_MSTATUS, mstatus_word(1'b0, 1'b1));
    check_bit(name, 1'b0, m_irq_enable);
    // save with mie clear leaves mpie clear
    pc_a = $random(seed);
    pc_b = $random(seed);
    trap_save(1'b0, pc_a, pc_b, 6'h0B, 1'b0, 32'h0);
    expect_csr(name, `CSR_ADDR_MEPC, pc_b);
    expect_csr(name, `CSR_ADDR_MCAUSE, cause_word(6'h0B));
    expect_csr(name, `CSR_ADDR_MSTATUS, mstatus_word(1'b0, 1'b0));
  endtask

  task automatic test_counter_events();
    string name;
    int    n_loads;
    name    = "test_counter_events";
    n_loads = 7;
    write_csr(1'b1, `CSR_ADDR_PCMR, CSR_OP_WRITE, 32'h3);
    write_csr(1'b1, `CSR_ADDR_PCER, CSR_OP_WRITE, 32'h0000_0020);
    write_csr(1'b1, `CSR_ADDR_PCCR_BASE + 12'd5, CSR_OP_WRITE, 32'h0);
    write_csr(1'b1, `CSR_ADDR_PCCR_BASE + 12'd6, CSR_OP_WRITE, 32'h0);
    pulse_loads(n_loads, 1'b1);
    expect_csr(name, `CSR_ADDR_PCCR_BASE + 12'd5, count_model(32'h0, n_loads, 1'b1));
    // stores not enabled in PCER
    expect_csr(name, `CSR_ADDR_PCCR_BASE + 12'd6, 32'h0);
    expect_csr(name, `CSR_ADDR_PCER, 32'h0000_0020);
    // global enable off
    write_csr(1'b1, `CSR_ADDR_PCMR, CSR_OP_WRITE, 32'h2);
    write_csr(1'b1, `CSR_ADDR_PCCR_BASE + 12'd5, CSR_OP_WRITE, 32'h0);
    pulse_loads(n_loads, 1'b0);
    expect_csr(name, `CSR_ADDR_PCCR_BASE + 12'd5, 32'h0);
    write_csr(1'b1, `CSR_ADDR_PCMR, CSR_OP_WRITE, 32'h3);
  endtask

  task automatic test_counter_saturation();
    string name;
    name = "test_counter_saturation";
    write_csr(1'b1, `CSR_ADDR_PCMR, CSR_OP_WRITE, 32'h3);
    write_csr(1'b1, `CSR_ADDR_PCCR_ALL, CSR_OP_WRITE, 32'hFFFF_FFFE);
    // alias reads as zero while every counter took the value
    check_now(name, 32'h0);
    expect_csr(name, `CSR_ADDR_PCCR_BASE + 12'd6, 32'hFFFF_FFFE);
    pulse_loads(3, 1'b0);
    expect_csr(name, `CSR_ADDR_PCCR_BASE + 12'd5, count_model(32'hFFFF_FFFE, 3, 1'b1));
    // wrap mode
    write_csr(1'b1, `CSR_ADDR_PCMR, CSR_OP_WRITE, 32'h1);
    write_csr(1'b1, `CSR_ADDR_PCCR_ALL, CSR_OP_WRITE, 32'hFFFF_FFFE);
    pulse_loads(3, 1'b0);
    expect_csr(name, `CSR_ADDR_PCCR_BASE + 12'd5, count_model(32'hFFFF_FFFE, 3, 1'b0));
  endtask

  //////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////

  initial begin
    seed         = 54;
    clk          = 1'b0;
    rst_n        = 1'b0;
    csr_access   = 1'b0;
    csr_addr     = '0;
    csr_op       = CSR_OP_NONE;
    csr_wdata    = '0;
    pc_if        = '0;
    pc_id        = '0;
    exc_save_if  = 1'b0;
    exc_save_id  = 1'b0;
    save_cause   = 1'b0;
    restore_mret = 1'b0;
    exc_cause    = '0;
    perf_events  = '0;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    test_reset_values();
    test_csr_ops();
    test_trap_save_mret();
    test_counter_events();
    test_counter_saturation();
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

// File: files.f
+incdir+hdl
hdl/csr_pkg.sv
hdl/csr_op_alu.sv
hdl/csr_trap_regs.sv
hdl/perf_counters.sv
hdl/csr_file.sv
test/csr_file_tb.sv

// File: Bender.yml
package:
  name: csr_file

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/csr_pkg.sv
      - hdl/csr_op_alu.sv
      - hdl/csr_trap_regs.sv
      - hdl/perf_counters.sv
      - hdl/csr_file.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - test/csr_file_tb.sv
